// ==== verilog/pcap_settings.svh ====
`ifndef PCAP_SETTINGS_SVH
`define PCAP_SETTINGS_SVH

// ==========================================================
// Stream and memory geometry
// ==========================================================
`define PCAP_DATA_BYTES     8
`define PCAP_DATA_W         (`PCAP_DATA_BYTES * 8)
`define PCAP_MEM_WORDS      256
`define PCAP_MEM_AW         $clog2(`PCAP_MEM_WORDS)
`define PCAP_LEN_W          ($clog2(`PCAP_MEM_WORDS * `PCAP_DATA_BYTES) + 1)

// Metadata field widths
`define PCAP_TID_W          8
`define PCAP_TDEST_W        12
`define PCAP_TUSER_W        32

// ==========================================================
// Register map, byte addresses
// ==========================================================
`define PCAP_REG_AW         12
`define PCAP_REG_CONTROL    12'h000
`define PCAP_REG_STATUS     12'h008
`define PCAP_REG_MEM_SIZE   12'h010
`define PCAP_REG_META_WIDTH 12'h018
`define PCAP_REG_LENGTH     12'h020
`define PCAP_REG_META       12'h028
`define PCAP_REG_DATA_BASE  12'h800

`endif

// ==== verilog/pcap_pkg.sv ====
`include "pcap_settings.svh"

package pcap_pkg;

    // ==========================================================
    // Stream side
    // ==========================================================
    typedef struct packed {
        logic [`PCAP_DATA_W-1:0]     tdata;
        logic [`PCAP_DATA_BYTES-1:0] tkeep;
        logic                        tlast;
        logic [`PCAP_TID_W-1:0]      tid;
        logic [`PCAP_TDEST_W-1:0]    tdest;
        logic [`PCAP_TUSER_W-1:0]    tuser;
    } axis_beat_t;

    // Captured once per packet
    typedef struct packed {
        logic [`PCAP_TID_W-1:0]   tid;
        logic [`PCAP_TDEST_W-1:0] tdest;
        logic [`PCAP_TUSER_W-1:0] tuser;
    } meta_t;

    typedef enum logic [1:0] {CAP_IDLE, CAP_ARMED, CAP_RECV, CAP_DONE} cap_state_e;

    // Single memory port
    typedef struct packed {
        logic                    req;
        logic                    we;
        logic [`PCAP_MEM_AW-1:0] addr;
        logic [`PCAP_DATA_W-1:0] wdata;
    } mem_req_t;

    // ==========================================================
    // Register bus
    // ==========================================================
    typedef enum logic [1:0] {REG_NOP, REG_READ, REG_WRITE} reg_op_e;

    typedef struct packed {
        reg_op_e                 op;
        logic [`PCAP_REG_AW-1:0] addr;
        logic [`PCAP_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`PCAP_DATA_W-1:0] rdata;
    } reg_rsp_t;

endpackage

// ==== verilog/pcap_mem.sv ====
`timescale 1ns/10ps
`include "pcap_settings.svh"

module pcap_mem (
    input  logic                    clk,
    input  pcap_pkg::mem_req_t      mem_req,
    output logic [`PCAP_DATA_W-1:0] mem_rdata
);

    // Packet storage, one stream beat per word
    logic [`PCAP_DATA_W-1:0] words [`PCAP_MEM_WORDS];

    always_ff @(posedge clk)
    begin
        if (mem_req.req)
        begin
            if (mem_req.we)
            begin
                words[mem_req.addr] <= mem_req.wdata;
            end
            else
            begin
                // Read data one cycle after the request
                mem_rdata <= words[mem_req.addr];
            end
        end
    end

endmodule

// ==== verilog/pcap_mem_arbiter.sv ====
`timescale 1ns/10ps
`include "pcap_settings.svh"

module pcap_mem_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pcap_pkg::mem_req_t      wr_req,
    input  pcap_pkg::mem_req_t      rd_req,
    output pcap_pkg::mem_req_t      mem_req,
    input  logic [`PCAP_DATA_W-1:0] mem_rdata,
    output pcap_pkg::reg_rsp_t      rd_rsp
);

    logic grant_wr;
    logic grant_rd;
    logic rd_inflight;

    // ==========================================================
    // Grant
    // ==========================================================
    // Writer always wins, so the stream never waits
    assign grant_wr = wr_req.req;
    assign grant_rd = rd_req.req && !wr_req.req && !rd_inflight;

    always_comb
    begin
        if (grant_wr)
        begin
            mem_req = wr_req;
        end
        else
        begin
            mem_req     = rd_req;
            mem_req.req = grant_rd;
        end
    end

    // ==========================================================
    // Read response
    // ==========================================================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_inflight <= 1'b0;
        end
        else
        begin
            rd_inflight <= grant_rd;
        end
    end

    // Memory data lines up with the cycle after the grant
    assign rd_rsp = '{valid: rd_inflight, rdata: mem_rdata};

endmodule

// ==== verilog/pcap_writer.sv ====
`timescale 1ns/10ps
`include "pcap_settings.svh"

module pcap_writer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   arm,
    input  logic                   clear,
    input  logic                   tvalid,
    input  pcap_pkg::axis_beat_t   beat,
    output logic                   tready,
    output pcap_pkg::mem_req_t     wr_req,
    output logic                   done,
    output logic                   overflow,
    output logic                   busy,
    output logic [`PCAP_LEN_W-1:0] length,
    output pcap_pkg::meta_t        meta
);

    import pcap_pkg::*;

    localparam int MEM_AW     = `PCAP_MEM_AW;
    localparam int CNT_W      = MEM_AW + 1;
    localparam int LEN_W      = `PCAP_LEN_W;
    localparam int KEEP_CNT_W = $clog2(`PCAP_DATA_BYTES) + 1;
    localparam logic [LEN_W-1:0] MAX_BYTES = LEN_W'(`PCAP_MEM_WORDS * `PCAP_DATA_BYTES);

    cap_state_e              state;
    logic [CNT_W-1:0]        word_cnt;
    logic [LEN_W-1:0]        byte_cnt;
    logic                    accept;
    logic                    mem_full;
    logic                    restart;
    logic                    wr_valid_q;
    logic [MEM_AW-1:0]       wr_addr_q;
    logic [`PCAP_DATA_W-1:0] wr_data_q;

    // Number of valid bytes in a beat
    function automatic logic [KEEP_CNT_W-1:0] keep_count(
        input logic [`PCAP_DATA_BYTES-1:0] keep
    );
        logic [KEEP_CNT_W-1:0] n;
        n = '0;
        for (int i = 0; i < `PCAP_DATA_BYTES; i++)
        begin
            n = n + KEEP_CNT_W'(keep[i]);
        end
        return n;
    endfunction

    assign tready   = (state == CAP_ARMED) || (state == CAP_RECV);
    assign accept   = tvalid && tready;
    assign mem_full = (word_cnt == CNT_W'(`PCAP_MEM_WORDS));
    // Clear wins over everything, arm alone only starts from idle
    assign restart  = clear || (arm && (state == CAP_IDLE));

    // ==========================================================
    // Capture FSM and counters
    // ==========================================================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= CAP_IDLE;
            word_cnt   <= '0;
            byte_cnt   <= '0;
            overflow   <= 1'b0;
            wr_valid_q <= 1'b0;
        end
        else
        begin
            wr_valid_q <= accept && !clear && !mem_full;
            if (restart)
            begin
                state    <= arm ? CAP_ARMED : CAP_IDLE;
                word_cnt <= '0;
                byte_cnt <= '0;
                overflow <= 1'b0;
            end
            else if (accept)
            begin
                if (mem_full)
                begin
                    // Beat dropped, length pinned at memory size
                    overflow <= 1'b1;
                    byte_cnt <= MAX_BYTES;
                end
                else
                begin
                    word_cnt <= word_cnt + 1'b1;
                    byte_cnt <= byte_cnt + LEN_W'(keep_count(beat.tkeep));
                end
                state <= beat.tlast ? CAP_DONE : CAP_RECV;
            end
        end
    end

    // Write request goes out the cycle after acceptance
    always_ff @(posedge clk)
    begin
        wr_addr_q <= word_cnt[MEM_AW-1:0];
        wr_data_q <= beat.tdata;
        if (accept && (state == CAP_ARMED))
        begin
            meta <= '{tid: beat.tid, tdest: beat.tdest, tuser: beat.tuser};
        end
    end

    assign wr_req = '{req: wr_valid_q, we: 1'b1, addr: wr_addr_q, wdata: wr_data_q};
    assign done   = (state == CAP_DONE);
    assign busy   = (state == CAP_RECV);
    assign length = byte_cnt;

endmodule

// ==== verilog/pcap_reg_ctrl.sv ====
`timescale 1ns/10ps
`include "pcap_settings.svh"

module pcap_reg_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pcap_pkg::reg_req_t     reg_req,
    output pcap_pkg::reg_rsp_t     reg_rsp,
    output logic                   arm,
    output logic                   clear,
    input  logic                   done,
    input  logic                   overflow,
    input  logic                   busy,
    input  logic [`PCAP_LEN_W-1:0] length,
    input  pcap_pkg::meta_t        meta,
    output pcap_pkg::mem_req_t     rd_req,
    input  pcap_pkg::reg_rsp_t     rd_rsp
);

    import pcap_pkg::*;

    localparam int DATA_W   = `PCAP_DATA_W;
    localparam int MEM_AW   = `PCAP_MEM_AW;
    localparam int WORD_LSB = $clog2(`PCAP_DATA_BYTES);

    logic              is_read;
    logic              is_write;
    logic              in_window;
    logic              ctrl_wr;
    logic [DATA_W-1:0] reg_rdata;
    logic              rsp_valid_q;
    logic [DATA_W-1:0] rsp_data_q;
    logic              rd_pending;
    logic [MEM_AW-1:0] rd_addr_q;

    assign is_read   = (reg_req.op == REG_READ);
    assign is_write  = (reg_req.op == REG_WRITE);
    assign in_window = (reg_req.addr >= `PCAP_REG_DATA_BASE);
    assign ctrl_wr   = is_write && (reg_req.addr == `PCAP_REG_CONTROL);

    // ==========================================================
    // Register read mux
    // ==========================================================
    always_comb
    begin
        case (reg_req.addr)
            `PCAP_REG_STATUS:     reg_rdata = DATA_W'({busy, overflow, done});
            `PCAP_REG_MEM_SIZE:   reg_rdata = DATA_W'(`PCAP_MEM_WORDS * `PCAP_DATA_BYTES);
            `PCAP_REG_META_WIDTH: reg_rdata = DATA_W'($bits(meta_t));
            `PCAP_REG_LENGTH:     reg_rdata = DATA_W'(length);
            `PCAP_REG_META:       reg_rdata = DATA_W'(meta);
            default:              reg_rdata = '0;
        endcase
    end

    // ==========================================================
    // Strobes, responses and window reads
    // ==========================================================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            arm         <= 1'b0;
            clear       <= 1'b0;
            rsp_valid_q <= 1'b0;
            rd_pending  <= 1'b0;
        end
        else
        begin
            arm         <= ctrl_wr && reg_req.wdata[0];
            clear       <= ctrl_wr && reg_req.wdata[1];
            rsp_valid_q <= is_read && !in_window;
            // Held until the arbiter answers
            if (is_read && in_window)
            begin
                rd_pending <= 1'b1;
            end
            else if (rd_rsp.valid)
            begin
                rd_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        rsp_data_q <= reg_rdata;
        if (is_read && in_window)
        begin
            rd_addr_q <= reg_req.addr[WORD_LSB +: MEM_AW];
        end
    end

    assign rd_req = '{req: rd_pending, we: 1'b0, addr: rd_addr_q, wdata: '0};

    // Memory data passes straight through when it arrives
    assign reg_rsp.valid = rsp_valid_q || rd_rsp.valid;
    assign reg_rsp.rdata = rd_rsp.valid ? rd_rsp.rdata : rsp_data_q;

endmodule

// ==== verilog/pcap_top.sv ====
`timescale 1ns/10ps
`include "pcap_settings.svh"

module pcap_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tvalid,
    input  pcap_pkg::axis_beat_t beat,
    output logic                 tready,
    input  pcap_pkg::reg_req_t   reg_req,
    output pcap_pkg::reg_rsp_t   reg_rsp
);

    import pcap_pkg::*;

    logic                    arm;
    logic                    clear;
    logic                    done;
    logic                    overflow;
    logic                    busy;
    logic [`PCAP_LEN_W-1:0]  length;
    meta_t                   meta;
    mem_req_t                wr_req;
    mem_req_t                rd_req;
    mem_req_t                mem_req;
    reg_rsp_t                rd_rsp;
    logic [`PCAP_DATA_W-1:0] mem_rdata;

    // ==========================================================
    // Capture path
    // ==========================================================
    pcap_writer pcap_writer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .arm      (arm),
        .clear    (clear),
        .tvalid   (tvalid),
        .beat     (beat),
        .tready   (tready),
        .wr_req   (wr_req),
        .done     (done),
        .overflow (overflow),
        .busy     (busy),
        .length   (length),
        .meta     (meta)
    );

    // Host side
    pcap_reg_ctrl pcap_reg_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp),
        .arm      (arm),
        .clear    (clear),
        .done     (done),
        .overflow (overflow),
        .busy     (busy),
        .length   (length),
        .meta     (meta),
        .rd_req   (rd_req),
        .rd_rsp   (rd_rsp)
    );

    // ==========================================================
    // Shared packet memory
    // ==========================================================
    pcap_mem_arbiter pcap_mem_arbiter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .rd_req    (rd_req),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .rd_rsp    (rd_rsp)
    );

    pcap_mem pcap_mem_inst (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== test/pcap_clk_gen.sv ====
`timescale 1ns/10ps

module pcap_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    // Free-running clock, 50 percent duty cycle
    initial
    begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== test/pcap_assert.sv ====
`timescale 1ns/10ps

module pcap_assert (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 tvalid,
    input pcap_pkg::axis_beat_t beat,
    input logic                 tready,
    input logic                 clear,
    input logic                 done,
    input logic                 overflow,
    input logic                 busy,
    input pcap_pkg::reg_rsp_t   reg_rsp,
    input pcap_pkg::mem_req_t   wr_req,
    input pcap_pkg::mem_req_t   mem_req,
    input pcap_pkg::reg_rsp_t   rd_rsp
);

    logic reader_grant;

    // Memory port carries a read, so the reader holds the grant
    assign reader_grant = mem_req.req && !mem_req.we;

    // ==========================================================
    // Reset and stream handshake
    // ==========================================================
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!tready && !reg_rsp.valid && !done && !overflow && !busy))
        else $error("outputs not quiet in the cycle after reset");

    // Accepted tlast holds the packet and closes the stream
    last_beat_ends_capture: assert property (@(posedge clk) disable iff (!rst_n)
        (tvalid && tready && beat.tlast && !clear) |=> (done && !tready))
        else $error("tready still high after the last beat was accepted");

    // ==========================================================
    // Memory arbitration
    // ==========================================================
    rsp_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
        rd_rsp.valid |-> $past(reader_grant))
        else $error("read response without a reader grant one cycle before");

    writer_first: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req.req |-> !reader_grant)
        else $error("reader granted while the writer requests the memory");

endmodule

bind pcap_top pcap_assert pcap_assert_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tvalid   (tvalid),
    .beat     (beat),
    .tready   (tready),
    .clear    (clear),
    .done     (done),
    .overflow (overflow),
    .busy     (busy),
    .reg_rsp  (reg_rsp),
    .wr_req   (wr_req),
    .mem_req  (mem_req),
    .rd_rsp   (rd_rsp)
);

// ==== test/pcap_tb.sv ====
`timescale 1ns/10ps
`include "pcap_settings.svh"

module pcap_tb;

    import pcap_pkg::*;

    localparam int SEED          = 63156;
    localparam int MEM_BYTES     = 2048;
    localparam int META_BITS     = 52;
    localparam int STREAM_COUNT  = 20;
    localparam int OVF_BEATS     = 300;
    localparam int PLANNED_BEATS = 4 + 25 + STREAM_COUNT * (25 + 4) + OVF_BEATS;
    localparam int PLANNED_READS = 5 + (STREAM_COUNT + 1) * 28 + 259;
    localparam int TIMEOUT_NS    = (PLANNED_BEATS + PLANNED_READS) * 8 * 4 + 2000;

    logic       clk;
    logic       rst_n;
    logic       tvalid;
    axis_beat_t beat;
    logic       tready;
    reg_req_t   reg_req;
    reg_rsp_t   reg_rsp;

    // Reference model of the packet in flight
    logic [63:0] model_words[$];
    int          model_bytes;
    int          model_len;
    meta_t       model_meta;

    int errors;
    int test_errors;
    int tests_passed;
    int tests_failed;
    bit verdict_printed;

    pcap_clk_gen clk_gen_inst (.clk(clk));

    pcap_top pcap_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .tvalid  (tvalid),
        .beat    (beat),
        .tready  (tready),
        .reg_req (reg_req),
        .reg_rsp (reg_rsp)
    );

    // ==========================================================
    // Checks and register bus
    // ==========================================================
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else
        begin
            $display("ERROR: %s expected 0x%h got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [63:0] data);
        @(posedge clk);
        reg_req <= '{op: REG_WRITE, addr: addr, wdata: data};
        @(posedge clk);
        reg_req <= '{op: REG_NOP, addr: '0, wdata: '0};
    endtask

    task automatic reg_read(input logic [11:0] addr, output logic [63:0] data);
        int wait_cycles;
        bit got;
        got         = 1'b0;
        wait_cycles = 0;
        data        = '0;
        @(posedge clk);
        reg_req <= '{op: REG_READ, addr: addr, wdata: '0};
        @(posedge clk);
        reg_req <= '{op: REG_NOP, addr: '0, wdata: '0};
        while (!got && wait_cycles < 16)
        begin
            @(negedge clk);
            if (reg_rsp.valid)
            begin
                got  = 1'b1;
                data = reg_rsp.rdata;
            end
            wait_cycles++;
        end
        if (!got)
        begin
            $display("register read at 0x%h got no response within 16 cycles", addr);
            errors++;
        end
    endtask

    // ==========================================================
    // Stream side
    // ==========================================================
    task automatic send_beat(input axis_beat_t b);
        int wait_cycles;
        wait_cycles = 0;
        @(posedge clk);
        tvalid <= 1'b1;
        beat   <= b;
        @(negedge clk);
        while (!tready && wait_cycles < 16)
        begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!tready)
        begin
            $display("stream beat was not accepted within 16 cycles");
            errors++;
        end
    endtask

    task automatic make_packet(input int nbytes);
        int nbeats;
        nbeats = (nbytes + 7) / 8;
        model_words.delete();
        model_bytes      = nbytes;
        model_len        = (nbytes > MEM_BYTES) ? MEM_BYTES : nbytes;
        model_meta.tid   = 8'($urandom);
        model_meta.tdest = 12'($urandom);
        model_meta.tuser = $urandom;
        for (int i = 0; i < nbeats; i++)
        begin
            model_words.push_back({$urandom, $urandom});
        end
    endtask

    task automatic send_packet();
        axis_beat_t b;
        int         nbeats;
        int         rem;
        nbeats = model_words.size();
        rem    = model_bytes % 8;
        for (int i = 0; i < nbeats; i++)
        begin
            b.tdata = model_words[i];
            // Short last beat keeps only its low bytes
            b.tkeep = (i == nbeats - 1 && rem != 0) ? (8'hff >> (8 - rem)) : 8'hff;
            b.tlast = (i == nbeats - 1);
            b.tid   = model_meta.tid;
            b.tdest = model_meta.tdest;
            b.tuser = model_meta.tuser;
            send_beat(b);
        end
        @(posedge clk);
        tvalid <= 1'b0;
    endtask

    task automatic offer_while_blocked(input int cycles);
        axis_beat_t b;
        b.tdata = {$urandom, $urandom};
        b.tkeep = 8'hff;
        b.tlast = 1'b1;
        b.tid   = 8'($urandom);
        b.tdest = 12'($urandom);
        b.tuser = $urandom;
        @(posedge clk);
        tvalid <= 1'b1;
        beat   <= b;
        repeat (cycles)
        begin
            @(negedge clk);
            check_value("tready", 64'h0, 64'(tready));
        end
        @(posedge clk);
        tvalid <= 1'b0;
    endtask

    task automatic verify_capture(input bit expect_overflow);
        logic [63:0] rdata;
        logic [63:0] mask;
        int          words;
        int          rem;
        reg_read(`PCAP_REG_STATUS, rdata);
        check_value("STATUS", expect_overflow ? 64'h3 : 64'h1, rdata);
        reg_read(`PCAP_REG_LENGTH, rdata);
        check_value("LENGTH", 64'(model_len), rdata);
        reg_read(`PCAP_REG_META, rdata);
        check_value("META", {12'h0, model_meta}, rdata);
        words = (model_words.size() > 256) ? 256 : model_words.size();
        rem   = model_bytes % 8;
        for (int i = 0; i < words; i++)
        begin
            mask = 64'hffff_ffff_ffff_ffff;
            if (i == model_words.size() - 1 && rem != 0)
            begin
                mask = 64'hffff_ffff_ffff_ffff >> (64 - 8 * rem);
            end
            reg_read(12'(`PCAP_REG_DATA_BASE + 8 * i), rdata);
            check_value($sformatf("DATA[%0d]", i), model_words[i] & mask, rdata & mask);
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors)
        begin
            tests_passed++;
            $display("test %-16s ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %-16s %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial
    begin
        logic [63:0] rdata;
        void'($urandom(SEED));
        rst_n   = 1'b0;
        tvalid  = 1'b0;
        beat    = '0;
        reg_req = '{op: REG_NOP, addr: '0, wdata: '0};
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        reg_read(`PCAP_REG_MEM_SIZE, rdata);
        check_value("MEM_SIZE", 64'(MEM_BYTES), rdata);
        reg_read(`PCAP_REG_META_WIDTH, rdata);
        check_value("META_WIDTH", 64'(META_BITS), rdata);
        finish_test("info_regs");

        // Not armed yet, nothing may be taken
        reg_read(`PCAP_REG_STATUS, rdata);
        check_value("STATUS", 64'h0, rdata);
        offer_while_blocked(4);
        reg_read(`PCAP_REG_STATUS, rdata);
        check_value("STATUS", 64'h0, rdata);
        reg_read(`PCAP_REG_LENGTH, rdata);
        check_value("LENGTH", 64'h0, rdata);
        finish_test("idle");

        reg_write(`PCAP_REG_CONTROL, 64'h1);
        make_packet(8 + int'($urandom % 193));
        send_packet();
        verify_capture(1'b0);
        finish_test("single_packet");

        for (int n = 0; n < STREAM_COUNT; n++)
        begin
            reg_write(`PCAP_REG_CONTROL, 64'h3);
            make_packet(8 + int'($urandom % 193));
            send_packet();
            offer_while_blocked(4);
            verify_capture(1'b0);
        end
        finish_test("packet_stream");

        reg_write(`PCAP_REG_CONTROL, 64'h3);
        make_packet(OVF_BEATS * 8);
        send_packet();
        verify_capture(1'b1);
        finish_test("overflow");

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, errors);
        verdict_printed = 1'b1;
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the planned beats and reads
    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        verdict_printed = 1'b1;
        $display("TEST FAILED");
        $finish;
    end

    // Run stopped early, e.g. by a failed bound assertion
    final
    begin
        if (!verdict_printed)
        begin
            $display("TEST FAILED");
        end
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/pcap_pkg.sv
verilog/pcap_mem.sv
verilog/pcap_mem_arbiter.sv
verilog/pcap_writer.sv
verilog/pcap_reg_ctrl.sv
verilog/pcap_top.sv
test/pcap_clk_gen.sv
test/pcap_assert.sv
test/pcap_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert --timescale 1ns/10ps
TOP      = pcap_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
